//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_hawk_pgwr_mngr
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- list.f
logic/hawk_pgwr_pkg.sv
logic/hawk_pgwr_sequencer.sv
logic/hawk_tbl_pkt_builder.sv
logic/hawk_axi_wr_issue.sv
logic/hawk_pgwr_mngr.sv
verif/tb_mem_model.sv
verif/tb_hawk_pgwr_mngr.sv

//--- logic/hawk_axi_wr_issue.sv
/*
 * write issue stage
 * one packet slot driving the address then data channel,
 * with the outstanding response counter and sticky bus error
 */
`timescale 1ns/1ps

module hawk_axi_wr_issue import hawk_pgwr_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       pkt_valid,
	input  addr_t      pkt_addr,
	input  line_t      pkt_data,
	input  strb_t      pkt_strb,
	input  logic       awready,
	input  logic       wready,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	output logic       awvalid,
	output addr_t      awaddr,
	output logic       wvalid,
	output line_t      wdata,
	output strb_t      wstrb,
	output logic       slot_free,
	output logic       wr_idle,
	output logic       bus_error
);

	logic              slot_empty;
	logic              aw_acc;
	logic              b_ok;
	logic [OUTS_W-1:0] outs_cnt;	// responses still owed

	assign slot_empty = !awvalid && !wvalid;
	assign aw_acc     = awvalid && awready;
	assign b_ok       = bvalid && (bresp == 2'b00);
	// stall new ops while the response window is full
	assign slot_free  = slot_empty && (outs_cnt < OUTS_W'(MAX_OUTSTANDING));
	assign wr_idle    = slot_empty && (outs_cnt == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
		end else begin
			if (pkt_valid)
				awvalid <= 1'b1;	// address phase first
			else if (aw_acc)
				awvalid <= 1'b0;
			if (aw_acc)
				wvalid <= 1'b1;	// data follows in the next cycle
			else if (wvalid && wready)
				wvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (pkt_valid) begin
			awaddr <= pkt_addr;
			wdata  <= pkt_data;
			wstrb  <= pkt_strb;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			outs_cnt  <= '0;
			bus_error <= 1'b0;
		end else begin
			if (aw_acc && !b_ok)
				outs_cnt <= outs_cnt + 1'b1;
			else if (!aw_acc && b_ok && (outs_cnt != '0))
				outs_cnt <= outs_cnt - 1'b1;
			if (bvalid && ((bresp != 2'b00) || (outs_cnt == '0)))
				bus_error <= 1'b1;	// error response or unexpected response
		end
	end

	a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(awaddr));
	a_slot_load: assert property (@(posedge clk_i) disable iff (!rst_ni)
		pkt_valid |-> slot_empty);
	a_outs_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		outs_cnt <= OUTS_W'(MAX_OUTSTANDING));

endmodule

//--- logic/hawk_pgwr_mngr.sv
/*
 * page-table write manager top
 * sequencer, packet builder and write issue stage in one pipeline
 */
`timescale 1ns/1ps

module hawk_pgwr_mngr import hawk_pgwr_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	// command side
	input  logic       init_att,
	input  logic       init_list,
	input  logic       tbl_update,
	input  att_idx_t   att_entry_id,
	input  list_idx_t  tol_entry_id,
	input  way_t       upd_way,
	input  list_idx_t  upd_next,
	input  list_id_t   src_list,
	output logic       init_att_done,
	output logic       init_list_done,
	output logic       mngr_ready,
	output logic       tbl_update_done,
	output logic       bus_error,
	output list_idx_t  free_head,
	output list_idx_t  free_tail,
	output list_idx_t  uncomp_head,
	output list_idx_t  uncomp_tail,
	// write port
	output logic       awvalid,
	output addr_t      awaddr,
	input  logic       awready,
	output logic       wvalid,
	output line_t      wdata,
	output strb_t      wstrb,
	input  logic       wready,
	input  logic       bvalid,
	input  logic [1:0] bresp
);

	logic      op_valid;
	wr_op_t    op;
	list_idx_t op_idx;
	list_idx_t op_ptr;
	way_t      op_way;
	att_sts_t  op_sts;
	logic      pkt_valid;
	addr_t     pkt_addr;
	line_t     pkt_data;
	strb_t     pkt_strb;
	logic      slot_free;	// back-pressure to the sequencer
	logic      wr_idle;

	hawk_pgwr_sequencer u_seq (.*);	// ports match by name

	hawk_tbl_pkt_builder u_build (.*);

	hawk_axi_wr_issue u_issue (.*);

endmodule

//--- logic/hawk_pgwr_pkg.sv
/*
 * page-table write manager shared definitions
 * table geometry, base addresses, entry encodings and the FSM and opcode enums
 */
package hawk_pgwr_pkg;

	// table geometry
	localparam int ATT_ENTRY_CNT   = 16;
	localparam int LIST_ENTRY_CNT  = 8;
	localparam int LINE_BYTES      = 64;
	localparam int ATT_PER_LINE    = 8;	// 8 byte att entries
	localparam int LIST_PER_LINE   = 4;	// 16 byte list entries
	localparam int MAX_OUTSTANDING = 16;	// write responses in flight

	// one index width serves both tables, the att table is the larger one
	localparam int IDX_W  = $clog2(ATT_ENTRY_CNT + 1);
	localparam int OUTS_W = $clog2(MAX_OUTSTANDING + 1);

	typedef logic [63:0]      addr_t;
	typedef logic [511:0]     line_t;
	typedef logic [63:0]      strb_t;
	typedef logic [49:0]      way_t;	// physical page number
	typedef logic [IDX_W-1:0] list_idx_t;	// index 0 is null
	typedef logic [IDX_W-1:0] att_idx_t;	// counted from 1

	// table placement in memory
	localparam addr_t     ATT_BASE      = 64'h0000_0000_8000_0000;
	localparam addr_t     LIST_BASE     = 64'h0000_0000_8000_1000;
	localparam way_t      PPA_PAGE_BASE = 50'h0_0000_0008_0000;	// first page of the pool
	localparam list_idx_t NULL_IDX      = '0;

	typedef enum logic {
		LST_FREE,
		LST_UNCOMP
	} list_id_t;

	// att status field, bits 1:0 of an att entry
	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1,
		STS_COMP   = 2'd2
	} att_sts_t;

	typedef enum logic [2:0] {
		OP_ATT_INIT,	// whole att entry as deallocated
		OP_LIST_INIT,	// whole list entry of the initial free list
		OP_ATT_SET,	// att entry with new status and way
		OP_CLEAR_PREV,	// prev pointer of the new source head
		OP_PUSH_SELF,	// prev and next of the moved entry
		OP_LINK_TAIL	// next pointer of the old tail
	} wr_op_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INIT_ATT,
		ST_INIT_LIST,
		ST_ATT_SET,
		ST_POP,
		ST_PUSH_SELF,
		ST_LINK_TAIL,
		ST_DRAIN
	} seq_state_t;

endpackage

//--- logic/hawk_pgwr_sequencer.sv
/*
 * page-table write sequencer
 * orders the att and list writes of init and update commands
 * and owns the free and uncompressed list head and tail registers
 */
`timescale 1ns/1ps

module hawk_pgwr_sequencer import hawk_pgwr_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       init_att,
	input  logic       init_list,
	input  logic       tbl_update,	// one cycle command strobe
	input  att_idx_t   att_entry_id,
	input  list_idx_t  tol_entry_id,
	input  way_t       upd_way,
	input  list_idx_t  upd_next,	// next pointer of the entry being moved
	input  list_id_t   src_list,
	input  logic       slot_free,
	input  logic       wr_idle,
	output logic       op_valid,
	output wr_op_t     op,
	output list_idx_t  op_idx,
	output list_idx_t  op_ptr,
	output way_t       op_way,
	output att_sts_t   op_sts,
	output logic       init_att_done,
	output logic       init_list_done,
	output logic       mngr_ready,
	output logic       tbl_update_done,
	output list_idx_t  free_head,
	output list_idx_t  free_tail,
	output list_idx_t  uncomp_head,
	output list_idx_t  uncomp_tail
);

	seq_state_t state_q, state_d;
	list_idx_t  cnt_q, cnt_d;	// entry counter for both inits
	logic       job_att_q, job_att_d;
	logic       job_list_q, job_list_d;
	logic       strobe_q;	// op strobed last cycle, still in the builder
	logic       can_issue;
	logic       start_upd;
	logic       finish;
	list_idx_t  fh_d, ft_d, uh_d, ut_d;
	list_idx_t  src_head, src_tail;

	// captured update command
	att_idx_t   att_id_q;
	list_idx_t  tol_id_q;
	list_idx_t  next_q;
	way_t       way_q;
	list_id_t   src_q;

	assign can_issue  = slot_free && !strobe_q;
	assign mngr_ready = (state_q == ST_IDLE);
	assign src_head   = (src_q == LST_FREE) ? free_head : uncomp_head;
	assign src_tail   = (src_q == LST_FREE) ? free_tail : uncomp_tail;

	always_comb begin
		state_d    = state_q;
		cnt_d      = cnt_q;
		job_att_d  = job_att_q;
		job_list_d = job_list_q;
		fh_d       = free_head;
		ft_d       = free_tail;
		uh_d       = uncomp_head;
		ut_d       = uncomp_tail;
		start_upd  = 1'b0;
		finish     = 1'b0;
		op_valid   = 1'b0;
		op         = OP_ATT_INIT;
		op_idx     = cnt_q;
		op_ptr     = NULL_IDX;
		op_way     = '0;
		op_sts     = STS_DALLOC;
		unique case (state_q)
			ST_IDLE: begin
				if (init_att && !init_att_done) begin	// inits take priority
					state_d   = ST_INIT_ATT;
					cnt_d     = list_idx_t'(1);
					job_att_d = 1'b1;
				end else if (init_list && !init_list_done) begin
					state_d    = ST_INIT_LIST;
					cnt_d      = list_idx_t'(1);
					job_list_d = 1'b1;
				end else if (tbl_update) begin
					state_d   = ST_ATT_SET;
					start_upd = 1'b1;
				end
			end
			ST_INIT_ATT: begin
				if (can_issue) begin
					op_valid = 1'b1;
					cnt_d    = cnt_q + 1'b1;
					if (cnt_q == list_idx_t'(ATT_ENTRY_CNT))
						state_d = ST_DRAIN;
				end
			end
			ST_INIT_LIST: begin
				op = OP_LIST_INIT;
				if (can_issue) begin
					op_valid = 1'b1;
					cnt_d    = cnt_q + 1'b1;
					if (cnt_q == list_idx_t'(LIST_ENTRY_CNT)) begin
						fh_d    = list_idx_t'(1);	// one free list over all entries
						ft_d    = list_idx_t'(LIST_ENTRY_CNT);
						uh_d    = NULL_IDX;
						ut_d    = NULL_IDX;
						state_d = ST_DRAIN;
					end
				end
			end
			ST_ATT_SET: begin
				op     = OP_ATT_SET;
				op_idx = list_idx_t'(att_id_q);
				op_way = way_q;
				op_sts = (src_q == LST_FREE) ? STS_UNCOMP : STS_COMP;	// free pages come in uncompressed
				if (can_issue) begin
					op_valid = 1'b1;
					state_d  = ST_POP;
				end
			end
			ST_POP: begin
				op     = OP_CLEAR_PREV;
				op_idx = next_q;	// new source head loses its prev
				if (src_head == src_tail) begin	// last entry, list empties without a write
					if (src_q == LST_FREE) begin
						fh_d = NULL_IDX;
						ft_d = NULL_IDX;
					end else begin
						uh_d = NULL_IDX;
						ut_d = NULL_IDX;
					end
					state_d = ST_PUSH_SELF;
				end else if (can_issue) begin
					op_valid = 1'b1;
					if (src_q == LST_FREE)
						fh_d = next_q;
					else
						uh_d = next_q;
					state_d = ST_PUSH_SELF;
				end
			end
			ST_PUSH_SELF: begin
				op     = OP_PUSH_SELF;
				op_idx = tol_id_q;
				op_ptr = uncomp_tail;	// prev of the moved entry
				if (can_issue) begin
					op_valid = 1'b1;
					if (uncomp_tail == NULL_IDX) begin
						uh_d    = tol_id_q;
						ut_d    = tol_id_q;
						state_d = ST_DRAIN;
					end else begin
						state_d = ST_LINK_TAIL;
					end
				end
			end
			ST_LINK_TAIL: begin
				op     = OP_LINK_TAIL;
				op_idx = uncomp_tail;
				op_ptr = tol_id_q;
				if (can_issue) begin
					op_valid = 1'b1;
					ut_d     = tol_id_q;
					state_d  = ST_DRAIN;
				end
			end
			ST_DRAIN: begin
				if (wr_idle && !strobe_q) begin	// builder empty too
					finish  = 1'b1;
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q         <= ST_IDLE;
			cnt_q           <= '0;
			job_att_q       <= 1'b0;
			job_list_q      <= 1'b0;
			strobe_q        <= 1'b0;
			free_head       <= NULL_IDX;
			free_tail       <= NULL_IDX;
			uncomp_head     <= NULL_IDX;
			uncomp_tail     <= NULL_IDX;
			init_att_done   <= 1'b0;
			init_list_done  <= 1'b0;
			tbl_update_done <= 1'b0;
		end else begin
			state_q         <= state_d;
			cnt_q           <= cnt_d;
			strobe_q        <= op_valid;
			free_head       <= fh_d;
			free_tail       <= ft_d;
			uncomp_head     <= uh_d;
			uncomp_tail     <= ut_d;
			tbl_update_done <= finish && !job_att_q && !job_list_q;
			if (finish && job_att_q)
				init_att_done <= 1'b1;	// sticky
			if (finish && job_list_q)
				init_list_done <= 1'b1;
			job_att_q  <= finish ? 1'b0 : job_att_d;
			job_list_q <= finish ? 1'b0 : job_list_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_upd) begin
			att_id_q <= att_entry_id;
			tol_id_q <= tol_entry_id;
			next_q   <= upd_next;
			way_q    <= upd_way;
			src_q    <= src_list;
		end
	end

	// the issue slot must be empty and the builder stage free
	a_op_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
		op_valid |-> slot_free);
	a_op_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
		op_valid |=> !op_valid);

endmodule

//--- logic/hawk_tbl_pkt_builder.sv
/*
 * table write packet builder
 * one registered stage from a write opcode to line address, data and strobe
 */
`timescale 1ns/1ps

module hawk_tbl_pkt_builder import hawk_pgwr_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_ni,
	input  logic      op_valid,
	input  wr_op_t    op,
	input  list_idx_t op_idx,
	input  list_idx_t op_ptr,
	input  way_t      op_way,
	input  att_sts_t  op_sts,
	output logic      pkt_valid,
	output addr_t     pkt_addr,
	output line_t     pkt_data,
	output strb_t     pkt_strb
);

	addr_t       n_addr;
	line_t       n_data;
	strb_t       n_strb;
	logic        is_att;
	list_idx_t   idx0;	// entry index counted from 0
	int unsigned slot;
	list_idx_t   init_next;

	// 8 byte att entry, zero-page count stays 0
	function automatic logic [63:0] att_entry(input att_sts_t sts, input way_t way);
		return {12'h000, way, sts};
	endfunction

	// 16 byte list entry with next, prev, way and a reserved top byte
	function automatic logic [127:0] list_entry(input list_idx_t nxt, input list_idx_t prv,
		input way_t way);
		return {8'h00, 6'h00, way, 32'(prv), 32'(nxt)};
	endfunction

	assign is_att    = (op == OP_ATT_INIT) || (op == OP_ATT_SET);
	assign idx0      = op_idx - 1'b1;
	assign init_next = (op_idx == list_idx_t'(LIST_ENTRY_CNT)) ? NULL_IDX : op_idx + 1'b1;

	always_comb begin
		n_data = '0;
		n_strb = '0;
		if (is_att) begin
			slot   = int'(idx0) % ATT_PER_LINE;
			n_addr = ATT_BASE + addr_t'(int'(idx0) / ATT_PER_LINE) * LINE_BYTES;
		end else begin
			slot   = int'(idx0) % LIST_PER_LINE;
			n_addr = LIST_BASE + addr_t'(int'(idx0) / LIST_PER_LINE) * LINE_BYTES;
		end
		unique case (op)
			OP_ATT_INIT: begin
				n_data[slot*64 +: 64] = att_entry(STS_DALLOC, '0);
				n_strb[slot*8 +: 8]   = '1;
			end
			OP_ATT_SET: begin
				n_data[slot*64 +: 64] = att_entry(op_sts, op_way);
				n_strb[slot*8 +: 8]   = '1;
			end
			OP_LIST_INIT: begin	// reserved byte is not written
				n_data[slot*128 +: 128] = list_entry(init_next, idx0,
					PPA_PAGE_BASE + way_t'(idx0));
				n_strb[slot*16 +: 15]   = '1;
			end
			OP_CLEAR_PREV: begin
				n_data[slot*128+32 +: 32] = 32'(op_ptr);	// prev field only
				n_strb[slot*16+4 +: 4]    = '1;
			end
			OP_PUSH_SELF: begin
				n_data[slot*128 +: 64] = {32'(op_ptr), 32'(NULL_IDX)};	// prev = old tail, next null
				n_strb[slot*16 +: 8]   = '1;
			end
			OP_LINK_TAIL: begin
				n_data[slot*128 +: 32] = 32'(op_ptr);	// next field only
				n_strb[slot*16 +: 4]   = '1;
			end
			default: n_strb = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			pkt_valid <= 1'b0;
		else
			pkt_valid <= op_valid;
	end

	always_ff @(posedge clk_i) begin
		if (op_valid) begin
			pkt_addr <= n_addr;
			pkt_data <= n_data;
			pkt_strb <= n_strb;
		end
	end

	// every opcode must map to some bytes
	a_strb_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
		pkt_valid |-> (pkt_strb != '0));

endmodule

//--- verif/tb_hawk_pgwr_mngr.sv
/*
 * testbench for the page-table write manager
 * runs both inits and a series of page moves against a random-delay memory slave
 */
`timescale 1ns/1ps

module tb_hawk_pgwr_mngr import hawk_pgwr_pkg::*; ();

	localparam int   EXP_WRITES  = ATT_ENTRY_CNT + LIST_ENTRY_CNT + 38;	// both inits then the moves
	localparam int   TIMEOUT_CYC = 40 * EXP_WRITES + 500;
	localparam way_t W1 = 50'h1_2345;
	localparam way_t W2 = 50'h2_abcd;

	logic clk_i, rst_ni, init_att, init_list, tbl_update;
	att_idx_t att_entry_id;
	list_idx_t tol_entry_id, upd_next;
	way_t upd_way;
	list_id_t src_list;
	logic init_att_done, init_list_done, mngr_ready, tbl_update_done, bus_error;
	list_idx_t free_head, free_tail, uncomp_head, uncomp_tail;
	logic awvalid, awready, wvalid, wready, bvalid, err_once;
	addr_t awaddr;
	line_t wdata;
	strb_t wstrb;
	logic [1:0] bresp;
	int wr_cnt, bad_cnt;
	int n_err, n_checks, n_tests, err_at_start, cyc_cnt;
	string test_name;

	hawk_pgwr_mngr UUT (.*);
	tb_mem_model u_mem (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	function automatic logic [7:0] read_byte(input addr_t a);
		return u_mem.mem[8'({a[12], a[6:0]})];
	endfunction

	// att entry n counted from 1
	function automatic logic [63:0] att_word(input int n);
		addr_t       a;
		logic [63:0] w;
		a = ATT_BASE + addr_t'((n-1) / ATT_PER_LINE * LINE_BYTES +
			(n-1) % ATT_PER_LINE * 8);
		for (int b = 0; b < 8; b++)
			w[b*8 +: 8] = read_byte(a + addr_t'(b));
		return w;
	endfunction

	// len bytes of list entry n from byte off, next at 0, prev at 4, way at 8
	function automatic logic [63:0] list_bytes(input int n, input int off, input int len);
		addr_t       a;
		logic [63:0] v;
		a = LIST_BASE + addr_t'((n-1) / LIST_PER_LINE * LINE_BYTES +
			(n-1) % LIST_PER_LINE * 16 + off);
		v = '0;
		for (int b = 0; b < len; b++)
			v[b*8 +: 8] = read_byte(a + addr_t'(b));
		return v;
	endfunction

	task automatic check_eq(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		n_checks++;
		assert (act === exp) else begin
			n_err++;
			$display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic step();
		@(posedge clk_i);
		#2;	// drive and sample away from the edge
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		err_at_start = n_err;
		n_tests++;
	endtask

	task automatic finish_test();
		$display("%s: done, %0d errors", test_name, n_err - err_at_start);
	endtask

	task automatic send_update(input int att, input int tol, input way_t way, input int nxt,
		input list_id_t src);
		while (!mngr_ready)
			step();
		tbl_update   = 1'b1;	// one cycle strobe
		att_entry_id = att_idx_t'(att);
		tol_entry_id = list_idx_t'(tol);
		upd_way      = way;
		upd_next     = list_idx_t'(nxt);
		src_list     = src;
		step();
		tbl_update = 1'b0;
	endtask

	task automatic move_page(input int att, input int tol, input way_t way, input int nxt,
		input list_id_t src);
		send_update(att, tol, way, nxt, src);
		while (!tbl_update_done)
			step();
	endtask

	initial begin
		void'($urandom(97));
		{rst_ni, init_att, init_list, tbl_update, err_once} = '0;
		{att_entry_id, tol_entry_id, upd_next, upd_way} = '0;
		src_list = LST_FREE;
		{n_err, n_checks, n_tests, err_at_start} = '0;
		repeat (10) @(posedge clk_i);
		#2 rst_ni = 1'b1;

		start_test("reset");
		check_eq("ctrl outputs", 64'(0), 64'({awvalid, wvalid, bus_error, tbl_update_done,
			init_att_done, init_list_done}));
		check_eq("mngr_ready", 64'(1), 64'(mngr_ready));
		check_eq("heads and tails", 64'(0),
			64'({free_head, free_tail, uncomp_head, uncomp_tail}));
		finish_test();

		start_test("att_init");
		init_att = 1'b1;
		do step(); while (!init_att_done);
		init_att = 1'b0;
		check_eq("write count", 64'(ATT_ENTRY_CNT), 64'(wr_cnt));
		for (int n = 1; n <= ATT_ENTRY_CNT; n++)
			check_eq($sformatf("att %0d", n), {12'h0, 50'h0, STS_DALLOC}, att_word(n));
		finish_test();

		start_test("list_init");
		init_list = 1'b1;
		do step(); while (!init_list_done);
		init_list = 1'b0;
		for (int i = 1; i <= LIST_ENTRY_CNT; i++) begin
			check_eq($sformatf("next %0d", i), 64'((i == LIST_ENTRY_CNT) ? 0 : i + 1),
				list_bytes(i, 0, 4));
			check_eq($sformatf("prev %0d", i), 64'(i - 1), list_bytes(i, 4, 4));
			check_eq($sformatf("way %0d", i), 64'(PPA_PAGE_BASE + way_t'(i - 1)),
				list_bytes(i, 8, 7));
		end
		check_eq("free_head", 64'(1), 64'(free_head));
		check_eq("free_tail", 64'(LIST_ENTRY_CNT), 64'(free_tail));
		finish_test();

		start_test("first_move");	// free head 1 moves to the empty uncompressed list
		move_page(3, 1, W1, 2, LST_FREE);
		check_eq("att 3", {12'h0, W1, STS_UNCOMP}, att_word(3));
		check_eq("free_head", 64'(2), 64'(free_head));
		check_eq("prev 2", 64'(0), list_bytes(2, 4, 4));
		check_eq("uncomp head/tail", 64'({5'd1, 5'd1}), 64'({uncomp_head, uncomp_tail}));
		check_eq("entry 1 links", 64'(0), list_bytes(1, 0, 8));
		finish_test();

		start_test("link_and_comp");
		move_page(5, 2, W2, 3, LST_FREE);
		check_eq("att 5", {12'h0, W2, STS_UNCOMP}, att_word(5));
		check_eq("next 1", 64'(2), list_bytes(1, 0, 4));
		check_eq("prev 2", 64'(1), list_bytes(2, 4, 4));
		check_eq("uncomp head/tail", 64'({5'd1, 5'd2}), 64'({uncomp_head, uncomp_tail}));
		move_page(3, 1, W1, 2, LST_UNCOMP);	// uncompressed head goes to its own tail
		check_eq("att 3", {12'h0, W1, STS_COMP}, att_word(3));
		check_eq("uncomp head/tail", 64'({5'd2, 5'd1}), 64'({uncomp_head, uncomp_tail}));
		check_eq("entry 2 links", {32'd0, 32'd1}, list_bytes(2, 0, 8));
		check_eq("entry 1 links", {32'd2, 32'd0}, list_bytes(1, 0, 8));
		finish_test();

		start_test("drain_free");	// pops the rest of the free list until it is empty
		for (int n = 3; n <= LIST_ENTRY_CNT; n++) begin
			move_page(n + 6, n, W2 + way_t'(n), (n == LIST_ENTRY_CNT) ? 0 : n + 1, LST_FREE);
			check_eq("att word", {12'h0, W2 + way_t'(n), STS_UNCOMP}, att_word(n + 6));
			check_eq("uncomp_tail", 64'(n), 64'(uncomp_tail));
			check_eq("prev", 64'((n == 3) ? 1 : n - 1), list_bytes(n, 4, 4));
			check_eq("old tail next", 64'(n), list_bytes((n == 3) ? 1 : n - 1, 0, 4));
			check_eq("free_head", 64'((n == LIST_ENTRY_CNT) ? 0 : n + 1), 64'(free_head));
		end
		check_eq("free_tail", 64'(0), 64'(free_tail));
		check_eq("stray writes", 64'(0), 64'(bad_cnt));
		finish_test();

		start_test("bus_error");	// erroring write never retires so no done pulse follows
		err_once = 1'b1;
		send_update(5, 2, W2, 1, LST_UNCOMP);
		do step(); while (!bus_error);
		repeat (10) step();
		check_eq("bus_error held", 64'(1), 64'(bus_error));
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
		if (n_err == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	always @(posedge clk_i) begin
		cyc_cnt++;
		if (cyc_cnt > TIMEOUT_CYC) begin
			$display("timeout: run exceeded %0d cycles in test %s", TIMEOUT_CYC, test_name);
			$display("Test failed");
			$finish;
		end
	end

	a_err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error |=> bus_error)
		else begin
			n_err++;
			$display("bus_error dropped after it was set");
		end
	a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
		tbl_update_done |=> !tbl_update_done)
		else begin
			n_err++;
			$display("tbl_update_done lasted more than one cycle");
		end
	a_att_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		init_att_done |=> init_att_done)
		else begin
			n_err++;
			$display("init_att_done fell after it rose");
		end
	a_list_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		init_list_done |=> init_list_done)
		else begin
			n_err++;
			$display("init_list_done fell after it rose");
		end
	a_data_after_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wvalid |-> !awvalid)
		else begin
			n_err++;
			$display("data phase overlapped a pending address phase");
		end

endmodule

//--- verif/tb_mem_model.sv
/*
 * memory slave for the write manager testbench
 * random ready and response delays, byte-strobed storage, in-order responses
 */
`timescale 1ns/1ps

module tb_mem_model import hawk_pgwr_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       awvalid,
	input  addr_t      awaddr,
	output logic       awready,
	input  logic       wvalid,
	input  line_t      wdata,
	input  strb_t      wstrb,
	output logic       wready,
	output logic       bvalid,
	output logic [1:0] bresp,
	input  logic       err_once,	// one write gets an error response
	output int         wr_cnt,
	output int         bad_cnt	// writes outside both tables
);

	logic [7:0] mem [0:255];	// index {addr[12], addr[6:0]}, att half then list half
	addr_t      aw_q[$];	// accepted addresses waiting for data
	int         b_due[$];	// cycle each response becomes due
	logic       b_err[$];
	int         cyc;
	logic       err_used;
	addr_t      a;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'hc3 ^ 8'(i * 7);	// pattern over the whole index, so stale bytes show
		awready  = 1'b0;
		wready   = 1'b0;
		bvalid   = 1'b0;
		bresp    = 2'b00;
		wr_cnt   = 0;
		bad_cnt  = 0;
		cyc      = 0;
		err_used = 1'b0;
	end

	always @(posedge clk_i) begin
		cyc++;
		if (rst_ni && awvalid && awready)
			aw_q.push_back(awaddr);
		if (rst_ni && wvalid && wready) begin
			a = aw_q.pop_front();
			if (!((a >= ATT_BASE && a < ATT_BASE + addr_t'(ATT_ENTRY_CNT * 8)) ||
				(a >= LIST_BASE && a < LIST_BASE + addr_t'(LIST_ENTRY_CNT * 16))))
				bad_cnt++;
			for (int i = 0; i < LINE_BYTES; i++)
				if (wstrb[i])
					mem[8'({a[12], a[6:0]}) + 8'(i)] = wdata[i*8 +: 8];	// only strobed bytes
			wr_cnt++;
			b_due.push_back(cyc + 1 + int'($urandom % 4));
			b_err.push_back(err_once && !err_used);
			if (err_once)
				err_used = 1'b1;
		end
		#2;	// outputs change after the edge
		awready = rst_ni && ($urandom % 3 != 0);
		wready  = rst_ni && ($urandom % 3 != 0);
		bvalid  = 1'b0;
		bresp   = 2'b00;
		if (b_due.size() > 0 && b_due[0] <= cyc) begin	// in order, oldest first
			void'(b_due.pop_front());
			bvalid = 1'b1;
			bresp  = b_err.pop_front() ? 2'b10 : 2'b00;	// slave error
		end
	end

endmodule
